/* hw/synctimer_pkg.sv */
`default_nettype none

package synctimer_pkg;

    // timer geometry.
    localparam int unsigned timer_width = 64;

    // clock period in ns as num/den.
    localparam int unsigned period_num = 10;
    localparam int unsigned period_den = 3;

    // whole and fractional step per cycle.
    localparam int unsigned period_int  = period_num / period_den;
    localparam int unsigned period_frac = period_num % period_den;
    localparam int unsigned frac_width  = $clog2(period_den);

    typedef logic [timer_width-1:0] time_t;
    typedef logic [frac_width-1:0]  frac_t;
    typedef logic [7:0]             byte_t;
    typedef logic [7:0]             node_t;
    typedef logic [7:0]             seq_t;
    typedef logic [15:0]            length_t;

    // command ids.
    localparam byte_t cmd_sync          = 8'h00;
    localparam byte_t cmd_sync_override = 8'h01;
    localparam byte_t cmd_probe         = 8'h10;

    // fixed offset carried in every sync frame.
    localparam logic [31:0] sync_offset = 32'd1000;

    // frame and payload sizes in bytes.
    localparam length_t sync_frame_len    = 16'd13;
    localparam length_t probe_frame_len   = 16'd3;
    localparam length_t probe_payload_len = 16'd9;

endpackage

`default_nettype wire

/* hw/cmd_stream_if.sv */
`default_nettype none

interface cmd_stream_if;

    synctimer_pkg::byte_t data;
    logic                 last;
    logic                 valid;
    logic                 ready;

    modport source (
        output data,
        output last,
        output valid,
        input  ready
    );

    modport sink (
        input  data,
        input  last,
        input  valid,
        output ready
    );

endinterface

`default_nettype wire

/* hw/sync_timer.sv */
`default_nettype none

module sync_timer (
    input  logic                 clk,
    input  logic                 reset,
    input  synctimer_pkg::time_t set_time,
    input  logic                 set_valid,
    output synctimer_pkg::time_t current_time
);

    synctimer_pkg::frac_t                acc;
    logic [synctimer_pkg::frac_width:0]  acc_sum;
    logic [synctimer_pkg::frac_width:0]  acc_wrap;
    logic                                carry;

    // remainder accumulation.
    assign acc_sum = {1'b0, acc}
                   + (synctimer_pkg::frac_width + 1)'(synctimer_pkg::period_frac);

    assign carry = acc_sum >= (synctimer_pkg::frac_width + 1)'(synctimer_pkg::period_den);

    assign acc_wrap = carry
                    ? acc_sum - (synctimer_pkg::frac_width + 1)'(synctimer_pkg::period_den)
                    : acc_sum;

    always_ff @(posedge clk) begin
        if (reset) begin
            current_time <= '0;
            acc          <= '0;
        end else if (set_valid) begin
            current_time <= set_time;
            acc          <= '0;
        end else begin
            // extra ns whenever the remainder wraps.
            current_time <= current_time
                          + synctimer_pkg::time_t'(synctimer_pkg::period_int)
                          + synctimer_pkg::time_t'(carry);
            acc          <= synctimer_pkg::frac_t'(acc_wrap);
        end
    end

    acc_in_range: assert property (
        @(posedge clk) disable iff (reset)
        32'(acc) < synctimer_pkg::period_den
    );

endmodule

`default_nettype wire

/* hw/sync_cmd_builder.sv */
`default_nettype none

module sync_cmd_builder (
    input  logic                 clk,
    input  logic                 reset,
    input  synctimer_pkg::time_t current_time,
    input  logic                 sync_start,
    input  logic                 sync_override,
    cmd_stream_if.source         tx
);

    synctimer_pkg::byte_t [synctimer_pkg::sync_frame_len-1:0] data_sr;
    logic [synctimer_pkg::sync_frame_len-1:0]                 last_sr;
    logic                                                     valid;

    always_ff @(posedge clk) begin
        if (reset) begin
            valid <= 1'b0;
        end else if (sync_start && !valid) begin
            valid <= 1'b1;
        end else if (valid && tx.ready) begin
            valid <= !last_sr[0];
        end
    end

    // frame contents, loaded once then shifted out.
    always_ff @(posedge clk) begin
        if (sync_start && !valid) begin
            data_sr[0] <= sync_override ? synctimer_pkg::cmd_sync_override
                                        : synctimer_pkg::cmd_sync;
            for (int i = 0; i < 8; i++) begin
                data_sr[1 + i] <= current_time[8*i +: 8];
            end
            for (int i = 0; i < 4; i++) begin
                data_sr[9 + i] <= synctimer_pkg::sync_offset[8*i +: 8];
            end
            last_sr <= '0;
            last_sr[synctimer_pkg::sync_frame_len-1] <= 1'b1;
        end else if (valid && tx.ready) begin
            data_sr <= data_sr >> 8;
            last_sr <= last_sr >> 1;
        end
    end

    assign tx.data  = data_sr[0];
    assign tx.last  = last_sr[0];
    assign tx.valid = valid;

    // stalled byte must not move.
    hold_on_stall: assert property (
        @(posedge clk) disable iff (reset)
        tx.valid && !tx.ready |=> tx.valid && $stable(tx.data) && $stable(tx.last)
    );

endmodule

`default_nettype wire

/* hw/delay_probe_builder.sv */
`default_nettype none

module delay_probe_builder (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 probe_start,
    input  synctimer_pkg::node_t probe_node,
    cmd_stream_if.source         tx
);

    synctimer_pkg::length_t idx;
    synctimer_pkg::seq_t    seq;
    synctimer_pkg::node_t   node;
    logic                   valid;
    logic                   at_last;

    assign at_last = idx == synctimer_pkg::probe_frame_len - 16'd1;

    always_ff @(posedge clk) begin
        if (reset) begin
            valid <= 1'b0;
            idx   <= '0;
            seq   <= '0;
        end else if (probe_start && !valid) begin
            valid <= 1'b1;
            idx   <= '0;
        end else if (valid && tx.ready) begin
            if (at_last) begin
                valid <= 1'b0;
                seq   <= seq + 8'd1;
            end else begin
                idx <= idx + 16'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (probe_start && !valid) begin
            node <= probe_node;
        end
    end

    // id, node, then sequence.
    always_comb begin
        case (idx)
            16'd0:   tx.data = synctimer_pkg::cmd_probe;
            16'd1:   tx.data = node;
            default: tx.data = seq;
        endcase
    end

    assign tx.last  = at_last;
    assign tx.valid = valid;

endmodule

`default_nettype wire

/* hw/cmd_tx_arbiter.sv */
`default_nettype none

module cmd_tx_arbiter (
    input  logic                 clk,
    input  logic                 reset,
    cmd_stream_if.sink           sync_in,
    cmd_stream_if.sink           probe_in,
    output synctimer_pkg::byte_t out_data,
    output logic                 out_last,
    output logic                 out_valid,
    input  logic                 out_ready
);

    logic lock;
    logic sel;
    logic last_probe;
    logic grant_probe;
    logic xfer;

    // round robin between the two builders.
    always_comb begin
        if (lock) begin
            grant_probe = sel;
        end else if (sync_in.valid && probe_in.valid) begin
            grant_probe = !last_probe;
        end else begin
            grant_probe = probe_in.valid;
        end
    end

    assign out_data  = grant_probe ? probe_in.data  : sync_in.data;
    assign out_last  = grant_probe ? probe_in.last  : sync_in.last;
    assign out_valid = grant_probe ? probe_in.valid : sync_in.valid;

    assign sync_in.ready  = out_ready && !grant_probe;
    assign probe_in.ready = out_ready && grant_probe;

    assign xfer = out_valid && out_ready;

    // lock from the first presented byte until last transfers.
    always_ff @(posedge clk) begin
        if (reset) begin
            lock       <= 1'b0;
            sel        <= 1'b0;
            last_probe <= 1'b1;
        end else if (xfer && out_last) begin
            lock       <= 1'b0;
            last_probe <= grant_probe;
        end else if (out_valid) begin
            lock <= 1'b1;
            sel  <= grant_probe;
        end
    end

    grant_held: assert property (
        @(posedge clk) disable iff (reset)
        out_valid && !(xfer && out_last) |=> grant_probe == $past(grant_probe)
    );

endmodule

`default_nettype wire

/* hw/probe_response_monitor.sv */
`default_nettype none

module probe_response_monitor (
    input  logic                   clk,
    input  logic                   reset,
    input  synctimer_pkg::time_t   current_time,
    input  logic                   res_rx_start,
    input  logic                   res_rx_end,
    input  logic                   res_rx_error,
    input  synctimer_pkg::byte_t   res_rx_type,
    input  synctimer_pkg::node_t   res_rx_node,
    input  synctimer_pkg::length_t res_payload_pos,
    input  synctimer_pkg::byte_t   res_payload_data,
    input  logic                   res_payload_valid,
    output logic                   probe_done,
    output synctimer_pkg::node_t   probe_done_node,
    output synctimer_pkg::seq_t    probe_done_seq,
    output synctimer_pkg::time_t   probe_done_node_time,
    output synctimer_pkg::time_t   probe_done_arrival
);

    synctimer_pkg::time_t                        arrival;
    synctimer_pkg::seq_t                         seq_reg;
    synctimer_pkg::time_t                        time_reg;
    logic [synctimer_pkg::probe_payload_len-1:0] seen;
    logic                                        frame_ok;

    assign frame_ok = !res_rx_error
                   && res_rx_type == synctimer_pkg::cmd_probe
                   && &seen;

    // payload assembly.
    always_ff @(posedge clk) begin
        if (res_rx_start) begin
            arrival <= current_time;
            seen    <= '0;
        end
        if (res_payload_valid) begin
            for (int i = 0; i < synctimer_pkg::probe_payload_len; i++) begin
                if (res_payload_pos == synctimer_pkg::length_t'(i)) begin
                    seen[i] <= 1'b1;
                    if (i == 0) begin
                        seq_reg <= res_payload_data;
                    end else begin
                        time_reg[8*(i-1) +: 8] <= res_payload_data;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            probe_done <= 1'b0;
        end else begin
            probe_done <= res_rx_end && frame_ok;
        end
    end

    // results hold until the next good frame.
    always_ff @(posedge clk) begin
        if (res_rx_end && frame_ok) begin
            probe_done_node      <= res_rx_node;
            probe_done_seq       <= seq_reg;
            probe_done_node_time <= time_reg;
            probe_done_arrival   <= arrival;
        end
    end

endmodule

`default_nettype wire

/* hw/synctimer_master_top.sv */
`default_nettype none

module synctimer_master_top (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   sync_start,
    input  logic                   sync_override,
    input  logic                   probe_start,
    input  logic                   set_valid,
    input  synctimer_pkg::node_t   probe_node,
    input  synctimer_pkg::time_t   set_time,
    output synctimer_pkg::time_t   current_time,
    output synctimer_pkg::byte_t   m_cmd_tx_data,
    output logic                   m_cmd_tx_last,
    output logic                   m_cmd_tx_valid,
    input  logic                   m_cmd_tx_ready,
    input  logic                   res_rx_start,
    input  logic                   res_rx_end,
    input  logic                   res_rx_error,
    input  synctimer_pkg::byte_t   res_rx_type,
    input  synctimer_pkg::node_t   res_rx_node,
    input  synctimer_pkg::length_t res_payload_pos,
    input  synctimer_pkg::byte_t   res_payload_data,
    input  logic                   res_payload_valid,
    output logic                   probe_done,
    output synctimer_pkg::node_t   probe_done_node,
    output synctimer_pkg::seq_t    probe_done_seq,
    output synctimer_pkg::time_t   probe_done_node_time,
    output synctimer_pkg::time_t   probe_done_arrival
);

    cmd_stream_if sync_tx ();
    cmd_stream_if probe_tx ();

    sync_timer u_timer (
        .clk          (clk),
        .reset        (reset),
        .set_time     (set_time),
        .set_valid    (set_valid),
        .current_time (current_time)
    );

    sync_cmd_builder u_sync_builder (
        .clk           (clk),
        .reset         (reset),
        .current_time  (current_time),
        .sync_start    (sync_start),
        .sync_override (sync_override),
        .tx            (sync_tx.source)
    );

    delay_probe_builder u_probe_builder (
        .clk         (clk),
        .reset       (reset),
        .probe_start (probe_start),
        .probe_node  (probe_node),
        .tx          (probe_tx.source)
    );

    cmd_tx_arbiter u_arbiter (
        .clk       (clk),
        .reset     (reset),
        .sync_in   (sync_tx.sink),
        .probe_in  (probe_tx.sink),
        .out_data  (m_cmd_tx_data),
        .out_last  (m_cmd_tx_last),
        .out_valid (m_cmd_tx_valid),
        .out_ready (m_cmd_tx_ready)
    );

    probe_response_monitor u_monitor (
        .clk                  (clk),
        .reset                (reset),
        .current_time         (current_time),
        .res_rx_start         (res_rx_start),
        .res_rx_end           (res_rx_end),
        .res_rx_error         (res_rx_error),
        .res_rx_type          (res_rx_type),
        .res_rx_node          (res_rx_node),
        .res_payload_pos      (res_payload_pos),
        .res_payload_data     (res_payload_data),
        .res_payload_valid    (res_payload_valid),
        .probe_done           (probe_done),
        .probe_done_node      (probe_done_node),
        .probe_done_seq       (probe_done_seq),
        .probe_done_node_time (probe_done_node_time),
        .probe_done_arrival   (probe_done_arrival)
    );

endmodule

`default_nettype wire

/* bench/synctimer_checker.sv */
`default_nettype none

module synctimer_checker (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   set_valid,
    input  synctimer_pkg::time_t   set_time,
    input  logic                   sync_start,
    input  logic                   sync_override,
    input  logic                   probe_start,
    input  synctimer_pkg::node_t   probe_node,
    input  synctimer_pkg::time_t   current_time,
    input  synctimer_pkg::byte_t   m_cmd_tx_data,
    input  logic                   m_cmd_tx_last,
    input  logic                   m_cmd_tx_valid,
    input  logic                   m_cmd_tx_ready,
    input  logic                   res_rx_start,
    input  logic                   res_rx_end,
    input  logic                   res_rx_error,
    input  synctimer_pkg::byte_t   res_rx_type,
    input  synctimer_pkg::node_t   res_rx_node,
    input  synctimer_pkg::length_t res_payload_pos,
    input  synctimer_pkg::byte_t   res_payload_data,
    input  logic                   res_payload_valid,
    input  logic                   probe_done,
    input  synctimer_pkg::node_t   probe_done_node,
    input  synctimer_pkg::seq_t    probe_done_seq,
    input  synctimer_pkg::time_t   probe_done_node_time,
    input  synctimer_pkg::time_t   probe_done_arrival,
    output int                     tests_done,
    output int                     tests_failed,
    output int                     error_count
);
    timeunit 1ns;
    timeprecision 100ps;

    synctimer_pkg::time_t model_time;
    int unsigned          model_acc;
    int unsigned          since_load;
    synctimer_pkg::time_t hist [3];
    int                   watch;
    int                   timer_err;
    synctimer_pkg::byte_t sync_q [$];
    synctimer_pkg::byte_t probe_q [$];
    synctimer_pkg::seq_t  probe_seq;
    int                   frame_kind;
    int                   frame_err;
    logic                 served_any;
    logic                 served_probe;
    synctimer_pkg::byte_t exp_byte;
    logic                 exp_last;
    synctimer_pkg::byte_t resp_bytes [9];
    logic [8:0]           resp_seen;
    logic                 done_due;
    synctimer_pkg::node_t exp_node;
    synctimer_pkg::seq_t  exp_seq;
    synctimer_pkg::time_t exp_node_time;
    synctimer_pkg::time_t exp_arrival;
    int                   quiet;
    int                   resp_err;

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp, inout int errs);
        if (got !== exp) begin
            $display("[FAIL] %s = 0x%0h, expected 0x%0h", name, got, exp);
            error_count++;
            errs++;
        end
    endtask

    task automatic report_problem(input string what, inout int errs);
        $display("error: %s", what);
        error_count++;
        errs++;
    endtask

    task automatic close_test(input string name, input int errs);
        tests_done++;
        if (errs > 0) begin
            tests_failed++;
        end
        $display("test %0d %s: %s", tests_done, name, (errs == 0) ? "ok" : "failed");
    endtask

    initial begin
        tests_done   = 0;
        tests_failed = 0;
        error_count  = 0;
        timer_err    = 0;
        resp_err     = 0;
        frame_err    = 0;
    end

    always @(posedge clk) begin
        if (reset) begin
            model_time   = '0;
            model_acc    = 0;
            since_load   = 0;
            sync_q.delete();
            probe_q.delete();
            probe_seq    = '0;
            frame_kind   = 0;
            served_any   = 1'b0;
            served_probe = 1'b0;
            watch        = 0;
            quiet        = 0;
            done_due     = 1'b0;
        end else begin
            // timer against a 10/3 ns per cycle model.
            check_value("current_time", current_time, model_time, timer_err);
            if (since_load >= 3) begin
                check_value("current_time step", current_time - hist[2], 64'd10, timer_err);
            end
            hist[2] = hist[1];
            hist[1] = hist[0];
            hist[0] = current_time;
            if (watch > 0) begin
                watch--;
                if (watch == 0) begin
                    close_test("timer load", timer_err);
                end
            end
            if (set_valid) begin
                watch     = 10;
                timer_err = 0;
            end

            // expected frames, built only while that builder is idle.
            if (sync_start && sync_q.size() == 0) begin
                sync_q.push_back(sync_override ? synctimer_pkg::cmd_sync_override
                                               : synctimer_pkg::cmd_sync);
                for (int i = 0; i < 8; i++)
                    sync_q.push_back(model_time[8*i +: 8]);
                for (int i = 0; i < 4; i++)
                    sync_q.push_back(synctimer_pkg::sync_offset[8*i +: 8]);
            end
            if (probe_start && probe_q.size() == 0) begin
                probe_q.push_back(synctimer_pkg::cmd_probe);
                probe_q.push_back(probe_node);
                probe_q.push_back(probe_seq);
            end

            if (m_cmd_tx_valid && m_cmd_tx_ready) begin
                // a frame is locked from its first byte to its last.
                if (frame_kind == 0) begin
                    // when both are pending the one not served last goes first.
                    if (served_any && sync_q.size() > 0 && probe_q.size() > 0) begin
                        frame_kind = served_probe ? 1 : 2;
                    end else begin
                        frame_kind = (probe_q.size() > 0 && (sync_q.size() == 0
                                      || m_cmd_tx_data == synctimer_pkg::cmd_probe)) ? 2 : 1;
                    end
                    frame_err  = 0;
                end
                if (frame_kind == 1 && sync_q.size() > 0) begin
                    exp_byte = sync_q.pop_front();
                    exp_last = sync_q.size() == 0;
                end else if (frame_kind == 2 && probe_q.size() > 0) begin
                    exp_byte = probe_q.pop_front();
                    exp_last = probe_q.size() == 0;
                end else begin
                    report_problem("byte sent on the command stream with no frame pending",
                                   frame_err);
                    exp_byte = m_cmd_tx_data;
                    exp_last = 1'b1;
                end
                check_value("m_cmd_tx_data", m_cmd_tx_data, exp_byte, frame_err);
                check_value("m_cmd_tx_last", m_cmd_tx_last, exp_last, frame_err);
                if (exp_last) begin
                    close_test((frame_kind == 2) ? "probe frame" : "sync frame", frame_err);
                    if (frame_kind == 2) begin
                        probe_seq++;
                    end
                    served_any   = 1'b1;
                    served_probe = frame_kind == 2;
                    frame_kind   = 0;
                end
            end

            // probe_done is due one edge after a good res_rx_end.
            if (done_due) begin
                done_due = 1'b0;
                check_value("probe_done", probe_done, 64'd1, resp_err);
                check_value("probe_done_node", probe_done_node, exp_node, resp_err);
                check_value("probe_done_seq", probe_done_seq, exp_seq, resp_err);
                check_value("probe_done_node_time", probe_done_node_time, exp_node_time,
                            resp_err);
                check_value("probe_done_arrival", probe_done_arrival, exp_arrival, resp_err);
                close_test("probe response", resp_err);
            end else if (probe_done) begin
                report_problem("probe_done pulsed without a valid response", resp_err);
            end
            if (quiet > 0) begin
                quiet--;
                if (quiet == 0) begin
                    close_test("rejected response", resp_err);
                end
            end
            if (res_rx_start) begin
                exp_arrival = model_time;
                resp_seen   = '0;
            end
            if (res_payload_valid && res_payload_pos < 16'd9) begin
                resp_bytes[res_payload_pos] = res_payload_data;
                resp_seen[res_payload_pos]  = 1'b1;
            end
            if (res_rx_end) begin
                resp_err = 0;
                if (!res_rx_error && res_rx_type == synctimer_pkg::cmd_probe && &resp_seen) begin
                    done_due = 1'b1;
                    exp_node = res_rx_node;
                    exp_seq  = resp_bytes[0];
                    for (int i = 0; i < 8; i++)
                        exp_node_time[8*i +: 8] = resp_bytes[i + 1];
                end else begin
                    quiet = 16;
                end
            end

            if (set_valid) begin
                model_time = set_time;
                model_acc  = 0;
                since_load = 0;
            end else begin
                model_time = model_time
                           + 64'(synctimer_pkg::period_num / synctimer_pkg::period_den);
                model_acc  = model_acc + synctimer_pkg::period_num % synctimer_pkg::period_den;
                if (model_acc >= synctimer_pkg::period_den) begin
                    model_acc  = model_acc - synctimer_pkg::period_den;
                    model_time = model_time + 64'd1;
                end
                since_load++;
            end
        end
    end

endmodule

`default_nettype wire

/* bench/tb_synctimer_master.sv */
`default_nettype none

module tb_synctimer_master;
    timeunit 1ns;
    timeprecision 100ps;

    typedef enum int {
        k_set, k_sync, k_sync_ovr, k_probe, k_both, k_resp, k_resp_err, k_resp_type
    } kind_t;

    typedef struct packed {
        kind_t                kind;
        synctimer_pkg::node_t node;
        synctimer_pkg::time_t value;
        logic                 rand_ready;
    } entry_t;

    localparam int n_entries = 13;

    logic                   clk;
    logic                   reset;
    logic                   sync_start;
    logic                   sync_override;
    logic                   probe_start;
    logic                   set_valid;
    synctimer_pkg::node_t   probe_node;
    synctimer_pkg::time_t   set_time;
    synctimer_pkg::time_t   current_time;
    synctimer_pkg::byte_t   m_cmd_tx_data;
    logic                   m_cmd_tx_last;
    logic                   m_cmd_tx_valid;
    logic                   m_cmd_tx_ready;
    logic                   res_rx_start;
    logic                   res_rx_end;
    logic                   res_rx_error;
    synctimer_pkg::byte_t   res_rx_type;
    synctimer_pkg::node_t   res_rx_node;
    synctimer_pkg::length_t res_payload_pos;
    synctimer_pkg::byte_t   res_payload_data;
    logic                   res_payload_valid;
    logic                   probe_done;
    synctimer_pkg::node_t   probe_done_node;
    synctimer_pkg::seq_t    probe_done_seq;
    synctimer_pkg::time_t   probe_done_node_time;
    synctimer_pkg::time_t   probe_done_arrival;
    int                     tests_done;
    int                     tests_failed;
    int                     error_count;

    entry_t stim [n_entries];
    logic   rand_ready;
    logic   timed_out;
    int     expected;

    synctimer_master_top dut (.*);

    synctimer_checker chk (.*);

    always #4 clk = ~clk;

    // back-pressure on the command stream.
    always @(posedge clk) begin
        #1;
        m_cmd_tx_ready = rand_ready ? 1'($urandom % 2) : 1'b1;
    end

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic wait_tests(input int target);
        int cycles;
        cycles = 0;
        while (tests_done < target && cycles < 400) begin
            step();
            cycles++;
        end
        if (tests_done < target) begin
            $display("timeout: only %0d of %0d tests finished", tests_done, target);
            timed_out = 1'b1;
        end
    endtask

    task automatic drive_payload(input synctimer_pkg::length_t pos,
                                 input synctimer_pkg::byte_t data);
        res_payload_valid = 1'b1;
        res_payload_pos   = pos;
        res_payload_data  = data;
        step();
    endtask

    // response frame: start, nine payload bytes, then end.
    task automatic send_response(input entry_t e);
        res_rx_type  = (e.kind == k_resp_type) ? 8'h11 : synctimer_pkg::cmd_probe;
        res_rx_error = e.kind == k_resp_err;
        res_rx_node  = e.node;
        res_rx_start = 1'b1;
        step();
        res_rx_start = 1'b0;
        drive_payload(16'd0, e.node + 8'h40);
        for (int i = 1; i < 9; i++)
            drive_payload(16'(i), e.value[8*i-8 +: 8]);
        res_payload_valid = 1'b0;
        res_rx_end        = 1'b1;
        step();
        res_rx_end   = 1'b0;
        res_rx_error = 1'b0;
    endtask

    task automatic apply_entry(input entry_t e);
        rand_ready = e.rand_ready;
        case (e.kind)
            k_set: begin
                set_time  = e.value;
                set_valid = 1'b1;
                expected++;
            end
            k_sync, k_sync_ovr: begin
                sync_override = e.kind == k_sync_ovr;
                sync_start    = 1'b1;
                expected++;
            end
            k_probe, k_both: begin
                probe_node    = e.node;
                probe_start   = 1'b1;
                sync_override = 1'b0;
                sync_start    = e.kind == k_both;
                expected      = expected + ((e.kind == k_both) ? 2 : 1);
            end
            default: begin
                send_response(e);
                expected++;
            end
        endcase
        step();
        set_valid   = 1'b0;
        sync_start  = 1'b0;
        probe_start = 1'b0;
        wait_tests(expected);
    endtask

    initial begin
        void'($urandom(32'hd8cb));
        clk               = 1'b0;
        reset             = 1'b1;
        sync_start        = 1'b0;
        sync_override     = 1'b0;
        probe_start       = 1'b0;
        set_valid         = 1'b0;
        probe_node        = '0;
        set_time          = '0;
        m_cmd_tx_ready    = 1'b1;
        res_rx_start      = 1'b0;
        res_rx_end        = 1'b0;
        res_rx_error      = 1'b0;
        res_rx_type       = '0;
        res_rx_node       = '0;
        res_payload_pos   = '0;
        res_payload_data  = '0;
        res_payload_valid = 1'b0;
        rand_ready        = 1'b0;
        timed_out         = 1'b0;
        expected          = 0;

        // kind, node, time value, random ready.
        stim[0]  = '{k_set,       8'h00, 64'h0000_00ff_ffff_fff0, 1'b0};
        stim[1]  = '{k_sync,      8'h00, 64'h0,                   1'b0};
        stim[2]  = '{k_probe,     8'h21, 64'h0,                   1'b1};
        stim[3]  = '{k_both,      8'h05, 64'h0,                   1'b1};
        stim[4]  = '{k_sync_ovr,  8'h00, 64'h0,                   1'b1};
        stim[5]  = '{k_both,      8'h06, 64'h0,                   1'b1};
        stim[6]  = '{k_probe,     8'h22, 64'h0,                   1'b0};
        stim[7]  = '{k_resp,      8'h33, 64'h1122_3344_5566_7788, 1'b0};
        stim[8]  = '{k_resp_err,  8'h34, 64'h0bad_0bad_0bad_0bad, 1'b0};
        stim[9]  = '{k_resp_type, 8'h35, 64'h0123_4567_89ab_cdef, 1'b0};
        stim[10] = '{k_set,       8'h00, 64'hffff_ffff_ffff_fff8, 1'b0};
        stim[11] = '{k_sync,      8'h00, 64'h0,                   1'b1};
        stim[12] = '{k_resp,      8'h36, 64'h8000_0000_0000_0a0a, 1'b1};

        repeat (16) @(posedge clk);
        #1;
        reset = 1'b0;

        for (int i = 0; i < n_entries; i++) begin
            if (!timed_out) begin
                apply_entry(stim[i]);
            end
        end
        step();

        $display("tests run: %0d, failed: %0d, check errors: %0d",
                 tests_done, tests_failed, error_count);
        if (!timed_out && error_count == 0 && tests_failed == 0 && tests_done == expected) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
hw/synctimer_pkg.sv
hw/cmd_stream_if.sv
hw/sync_timer.sv
hw/sync_cmd_builder.sv
hw/delay_probe_builder.sv
hw/cmd_tx_arbiter.sv
hw/probe_response_monitor.sv
hw/synctimer_master_top.sv
bench/synctimer_checker.sv
bench/tb_synctimer_master.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f verilog.f --top-module tb_synctimer_master -o sim_synctimer

sim_out=$(./obj_dir/sim_synctimer)
echo "$sim_out"

if grep -qF '*** PASSED ***' <<< "$sim_out"; then
    exit 0
fi
exit 1
